// File: logic/bus_pkg.sv
package bus_pkg;

  localparam int data_w = 32; // core-side address and data
  localparam int bus_w  = 64; // axi data bus
  localparam int strb_w = bus_w / 8;

  localparam logic [1:0] resp_okay = 2'b00;

  // axi size field, bytes per beat as a power of two
  typedef enum logic [2:0] {
    size_byte = 3'd0,
    size_half = 3'd1,
    size_word = 3'd2
  } axi_size_e;

  typedef enum logic [1:0] {
    kind_fetch,
    kind_load,
    kind_store,
    kind_timer // load from mtime, never reaches axi
  } req_kind_e;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait
  } arb_state_e;

endpackage

// File: logic/mem_map_pkg.sv
package mem_map_pkg;

  import bus_pkg::*;

  // core-local timer block
  localparam logic [data_w-1:0] clint_base = 32'ha000_0000;
  localparam logic [data_w-1:0] mtime_off  = 32'h0000_0048;

  // low and high words of mtime
  localparam logic [data_w-1:0] rtc_addr    = clint_base + mtime_off;
  localparam logic [data_w-1:0] rtc_addr_up = rtc_addr + 32'd4;

endpackage

// File: logic/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if
  import bus_pkg::*;
();

  logic              valid; // one-cycle pulse per request
  req_kind_e         kind;
  logic [data_w-1:0] addr;
  logic [strb_w-1:0] strb;
  logic [data_w-1:0] wdata;

  modport src (
    output valid,
    output kind,
    output addr,
    output strb,
    output wdata
  );

  modport dst (
    input valid,
    input kind,
    input addr,
    input strb,
    input wdata
  );

endinterface

// File: logic/req_arbiter.sv
`timescale 1ns/1ns

module req_arbiter
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [data_w-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  input  logic [data_w-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [strb_w-1:0] lsu_rstrb_i,
  input  logic [data_w-1:0] lsu_awaddr_i,
  input  logic [data_w-1:0] lsu_wdata_i,
  input  logic [strb_w-1:0] lsu_wstrb_i,
  input  logic              lsu_wvalid_i,
  input  logic              done_i,
  mem_req_if.src            req_o
);

  localparam logic [strb_w-1:0] fetch_strb = strb_w'(4'hf); // fetch is always a full word

  arb_state_e state_q;
  logic       any_req;
  logic       is_rtc;

  assign any_req = lsu_wvalid_i | lsu_arvalid_i | ifu_arvalid_i;
  assign is_rtc  = (lsu_araddr_i == rtc_addr) || (lsu_araddr_i == rtc_addr_up);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= st_idle;
      req_o.valid <= 1'b0;
    end
    else
    begin
      req_o.valid <= 1'b0;
      case (state_q)
        st_idle:
          if (any_req)
          begin
            state_q     <= st_issue;
            req_o.valid <= 1'b1; // grant pulse
          end
        st_issue:
          state_q <= st_wait;
        st_wait:
          if (done_i)
            state_q <= st_idle;
        default:
          state_q <= st_idle;
      endcase
    end
  end

  // latch the winner, store over load over fetch
  always_ff @(posedge clk)
  begin
    if (state_q == st_idle)
    begin
      if (lsu_wvalid_i)
      begin
        req_o.kind  <= kind_store;
        req_o.addr  <= lsu_awaddr_i;
        req_o.strb  <= lsu_wstrb_i;
        req_o.wdata <= lsu_wdata_i;
      end
      else if (lsu_arvalid_i)
      begin
        req_o.kind  <= is_rtc ? kind_timer : kind_load;
        req_o.addr  <= lsu_araddr_i;
        req_o.strb  <= lsu_rstrb_i;
        req_o.wdata <= '0;
      end
      else
      begin
        req_o.kind  <= kind_fetch;
        req_o.addr  <= ifu_araddr_i;
        req_o.strb  <= fetch_strb;
        req_o.wdata <= '0;
      end
    end
  end

  // completion only ever ends a granted transaction
  done_in_flight: assert property (
    @(posedge clk) disable iff (rst) done_i |-> state_q != st_idle
  );

endmodule

// File: logic/axi_issue.sv
`timescale 1ns/1ns

module axi_issue
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  mem_req_if.dst            req_i,
  mem_req_if.src            req_o,
  output logic [data_w-1:0] io_master_araddr_o,
  output axi_size_e         io_master_arsize_o,
  output logic              io_master_arvalid_o,
  input  logic              io_master_arready_i,
  output logic [data_w-1:0] io_master_awaddr_o,
  output axi_size_e         io_master_awsize_o,
  output logic              io_master_awvalid_o,
  input  logic              io_master_awready_i,
  output logic [bus_w-1:0]  io_master_wdata_o,
  output logic [strb_w-1:0] io_master_wstrb_o,
  output logic              io_master_wvalid_o,
  input  logic              io_master_wready_i
);

  logic [1:0]          byte_off;
  logic [data_w-1:0]   lane_data;
  logic [strb_w/2-1:0] lane_strb;
  axi_size_e           req_size;

  function automatic axi_size_e size_of(input logic [strb_w-1:0] strb);
    case (strb)
      strb_w'(4'h1): return size_byte;
      strb_w'(4'h3): return size_half;
      strb_w'(4'hf): return size_word;
      default:       return size_byte;
    endcase
  endfunction

  // forwarded copy doubles as the held request
  always_ff @(posedge clk)
  begin
    if (rst)
      req_o.valid <= 1'b0;
    else
      req_o.valid <= req_i.valid;
  end

  always_ff @(posedge clk)
  begin
    if (req_i.valid)
    begin
      req_o.kind  <= req_i.kind;
      req_o.addr  <= req_i.addr;
      req_o.strb  <= req_i.strb;
      req_o.wdata <= req_i.wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      io_master_arvalid_o <= 1'b0;
      io_master_awvalid_o <= 1'b0;
      io_master_wvalid_o  <= 1'b0;
    end
    else if (req_i.valid)
    begin
      io_master_arvalid_o <= (req_i.kind == kind_fetch) || (req_i.kind == kind_load);
      io_master_awvalid_o <= req_i.kind == kind_store;
      io_master_wvalid_o  <= req_i.kind == kind_store;
    end
    else
    begin
      if (io_master_arready_i)
        io_master_arvalid_o <= 1'b0;
      if (io_master_awready_i)
        io_master_awvalid_o <= 1'b0; // aw and w retire on their own
      if (io_master_wready_i)
        io_master_wvalid_o <= 1'b0;
    end
  end

  assign req_size = size_of(req_o.strb);
  assign byte_off = req_o.addr[1:0];

  assign io_master_araddr_o = req_o.addr;
  assign io_master_arsize_o = req_size;
  assign io_master_awaddr_o = req_o.addr;
  assign io_master_awsize_o = req_size;

  // move data and strobe onto the addressed byte lanes
  assign lane_data = req_o.wdata << {byte_off, 3'b000};
  assign lane_strb = req_o.strb[strb_w/2-1:0] << byte_off;

  assign io_master_wdata_o = {lane_data, lane_data};
  assign io_master_wstrb_o = req_o.addr[2] ? {lane_strb, {(strb_w/2){1'b0}}}
                                           : {{(strb_w/2){1'b0}}, lane_strb};

  ar_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    io_master_arvalid_o && !io_master_arready_i |=> $stable(io_master_araddr_o)
  );

endmodule

// File: logic/resp_router.sv
`timescale 1ns/1ns

module resp_router
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  mem_req_if.dst            req_i,
  input  logic [bus_w-1:0]  io_master_rdata_i,
  input  logic [1:0]        io_master_rresp_i,
  input  logic              io_master_rvalid_i,
  input  logic [1:0]        io_master_bresp_i,
  input  logic              io_master_bvalid_i,
  output logic              timer_rd_o,
  input  logic [data_w-1:0] timer_rdata_i,
  input  logic              timer_valid_i,
  output logic [data_w-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,
  output logic [data_w-1:0] lsu_rdata_o,
  output logic              lsu_rvalid_o,
  output logic              lsu_wready_o,
  output logic              done_o
);

  req_kind_e         kind_q;
  logic              upper_q;
  logic              pend_q;
  logic              rd_hit;
  logic              wr_hit;
  logic              tm_hit;
  logic [data_w-1:0] rd_word;

  assign timer_rd_o = req_i.valid && (req_i.kind == kind_timer);

  assign rd_hit = pend_q && io_master_rvalid_i && (kind_q == kind_fetch || kind_q == kind_load);
  assign wr_hit = pend_q && io_master_bvalid_i && (kind_q == kind_store);
  assign tm_hit = pend_q && timer_valid_i && (kind_q == kind_timer);

  assign rd_word = upper_q ? io_master_rdata_i[bus_w-1:data_w] : io_master_rdata_i[data_w-1:0];

  always_ff @(posedge clk)
  begin
    if (req_i.valid)
    begin
      kind_q  <= req_i.kind;
      upper_q <= req_i.addr[2]; // which half of the 64-bit beat
    end
    if (rd_hit && kind_q == kind_fetch)
      ifu_rdata_o <= rd_word;
    if (rd_hit || tm_hit)
      lsu_rdata_o <= tm_hit ? timer_rdata_i : rd_word;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pend_q       <= 1'b0;
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_wready_o <= 1'b0;
      done_o       <= 1'b0;
    end
    else
    begin
      if (req_i.valid)
        pend_q <= 1'b1;
      else if (rd_hit || wr_hit || tm_hit)
        pend_q <= 1'b0;
      ifu_rvalid_o <= rd_hit && kind_q == kind_fetch;
      lsu_rvalid_o <= (rd_hit && kind_q == kind_load) || tm_hit;
      lsu_wready_o <= wr_hit;
      done_o       <= rd_hit || wr_hit || tm_hit;
    end
  end

  rresp_okay: assert property (
    @(posedge clk) disable iff (rst) io_master_rvalid_i |-> io_master_rresp_i == resp_okay
  );
  bresp_okay: assert property (
    @(posedge clk) disable iff (rst) io_master_bvalid_i |-> io_master_bresp_i == resp_okay
  );

endmodule

// File: logic/clint_timer.sv
`timescale 1ns/1ns

module clint_timer
  import bus_pkg::*;
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_i,
  input  logic [data_w-1:0] addr_i,
  output logic [data_w-1:0] rdata_o,
  output logic              valid_o
);

  logic [2*data_w-1:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
      valid_o <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 1'b1; // one tick per cycle
      valid_o <= rd_i;
    end
  end

  // word select, anything but the high word reads low
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_o <= (addr_i == rtc_addr_up) ? mtime_q[2*data_w-1:data_w] : mtime_q[data_w-1:0];
  end

endmodule

// File: logic/mem_bus_top.sv
`timescale 1ns/1ns

module mem_bus_top
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  output logic [data_w-1:0] io_master_araddr_o,
  output logic [2:0]        io_master_arsize_o,
  output logic              io_master_arvalid_o,
  input  logic              io_master_arready_i,
  input  logic [bus_w-1:0]  io_master_rdata_i,
  input  logic [1:0]        io_master_rresp_i,
  input  logic              io_master_rvalid_i,
  output logic [data_w-1:0] io_master_awaddr_o,
  output logic [2:0]        io_master_awsize_o,
  output logic              io_master_awvalid_o,
  input  logic              io_master_awready_i,
  output logic [bus_w-1:0]  io_master_wdata_o,
  output logic [strb_w-1:0] io_master_wstrb_o,
  output logic              io_master_wvalid_o,
  input  logic              io_master_wready_i,
  input  logic [1:0]        io_master_bresp_i,
  input  logic              io_master_bvalid_i,

  input  logic [data_w-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  output logic [data_w-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,

  input  logic [data_w-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [strb_w-1:0] lsu_rstrb_i,
  output logic [data_w-1:0] lsu_rdata_o,
  output logic              lsu_rvalid_o,
  input  logic [data_w-1:0] lsu_awaddr_i,
  input  logic [data_w-1:0] lsu_wdata_i,
  input  logic [strb_w-1:0] lsu_wstrb_i,
  input  logic              lsu_wvalid_i,
  output logic              lsu_wready_o
);

  logic              done;
  logic              timer_rd;
  logic [data_w-1:0] timer_rdata;
  logic              timer_valid;

  mem_req_if req_a ();
  mem_req_if req_b ();

  req_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .done_i        (done),
    .req_o         (req_a.src)
  );

  axi_issue u_issue (
    .clk                 (clk),
    .rst                 (rst),
    .req_i               (req_a.dst),
    .req_o               (req_b.src),
    .io_master_araddr_o  (io_master_araddr_o),
    .io_master_arsize_o  (io_master_arsize_o),
    .io_master_arvalid_o (io_master_arvalid_o),
    .io_master_arready_i (io_master_arready_i),
    .io_master_awaddr_o  (io_master_awaddr_o),
    .io_master_awsize_o  (io_master_awsize_o),
    .io_master_awvalid_o (io_master_awvalid_o),
    .io_master_awready_i (io_master_awready_i),
    .io_master_wdata_o   (io_master_wdata_o),
    .io_master_wstrb_o   (io_master_wstrb_o),
    .io_master_wvalid_o  (io_master_wvalid_o),
    .io_master_wready_i  (io_master_wready_i)
  );

  resp_router u_router (
    .clk                (clk),
    .rst                (rst),
    .req_i              (req_b.dst),
    .io_master_rdata_i  (io_master_rdata_i),
    .io_master_rresp_i  (io_master_rresp_i),
    .io_master_rvalid_i (io_master_rvalid_i),
    .io_master_bresp_i  (io_master_bresp_i),
    .io_master_bvalid_i (io_master_bvalid_i),
    .timer_rd_o         (timer_rd),
    .timer_rdata_i      (timer_rdata),
    .timer_valid_i      (timer_valid),
    .ifu_rdata_o        (ifu_rdata_o),
    .ifu_rvalid_o       (ifu_rvalid_o),
    .lsu_rdata_o        (lsu_rdata_o),
    .lsu_rvalid_o       (lsu_rvalid_o),
    .lsu_wready_o       (lsu_wready_o),
    .done_o             (done)
  );

  // timer word picked by the address held in stage two
  clint_timer u_clint (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (timer_rd),
    .addr_i  (req_b.addr),
    .rdata_o (timer_rdata),
    .valid_o (timer_valid)
  );

endmodule

// File: test/axi_slave_model.sv
`timescale 1ns/1ns

module axi_slave_model
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o
);

  logic [63:0] mem [0:255];
  logic [31:0] ar_addr, aw_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;
  logic        ar_got, aw_got, w_got;
  int          ar_wait, r_wait, aw_wait, w_wait, b_wait;

  assign rresp_o = 2'b00;
  assign bresp_o = 2'b00;

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = {32'h1000_0000 + i * 32'h0001_0003, 32'hf000_0000 ^ (i * 32'h0003_0101)};
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      ar_got    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_wait   <= $urandom_range(0, 3);
      aw_wait   <= $urandom_range(0, 3);
      w_wait    <= $urandom_range(0, 3);
      r_wait    <= 0;
      b_wait    <= $urandom_range(0, 3);
    end
    else
    begin
      arready_o <= 1'b0; // ready and valid are single-cycle pulses here
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      if (arvalid_i && !arready_o && !ar_got)
      begin
        if (ar_wait == 0)
        begin
          arready_o <= 1'b1;
          ar_got    <= 1'b1;
          ar_addr   <= araddr_i;
          r_wait    <= $urandom_range(0, 3);
        end
        else
          ar_wait <= ar_wait - 1;
      end
      if (ar_got)
      begin
        if (r_wait == 0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[ar_addr[10:3]];
          ar_got   <= 1'b0;
          ar_wait  <= $urandom_range(0, 3);
        end
        else
          r_wait <= r_wait - 1;
      end
      if (awvalid_i && !awready_o && !aw_got)
      begin
        if (aw_wait == 0)
        begin
          awready_o <= 1'b1;
          aw_got    <= 1'b1;
          aw_addr   <= awaddr_i;
        end
        else
          aw_wait <= aw_wait - 1;
      end
      if (wvalid_i && !wready_o && !w_got)
      begin
        if (w_wait == 0)
        begin
          wready_o <= 1'b1;
          w_got    <= 1'b1;
          w_data   <= wdata_i;
          w_strb   <= wstrb_i;
        end
        else
          w_wait <= w_wait - 1;
      end
      if (aw_got && w_got)
      begin
        if (b_wait == 0)
        begin
          for (int b = 0; b < 8; b++)
            if (w_strb[b])
              mem[aw_addr[10:3]][8*b +: 8] <= w_data[8*b +: 8];
          bvalid_o <= 1'b1;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
          aw_wait  <= $urandom_range(0, 3);
          w_wait   <= $urandom_range(0, 3);
          b_wait   <= $urandom_range(0, 3);
        end
        else
          b_wait <= b_wait - 1;
      end
    end
  end

endmodule

// File: test/tb_mem_bus.sv
`timescale 1ns/1ns

module tb_mem_bus
  import mem_map_pkg::*;
();

  localparam int unsigned seed = 32'h44ae_aa12;
  localparam int n_fetch   = 30;
  localparam int n_rep     = 4; // per size and offset
  localparam int n_prio    = 16;
  localparam int n_timer   = 24;
  localparam int max_txn   = 200;
  localparam int cyc_limit = max_txn * 12;
  localparam int mem_words = 256;
  localparam int timer_lat = 3;

  logic clk, rst;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic        ifu_arvalid, lsu_arvalid, lsu_wvalid;
  logic [7:0]  lsu_rstrb, lsu_wstrb;
  logic [31:0] ifu_rdata_o, lsu_rdata_o;
  logic        ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o;
  logic [31:0] araddr, awaddr;
  logic [2:0]  arsize, awsize;
  logic        arvalid, arready, awvalid, awready, wvalid, wready, rvalid, bvalid;
  logic [63:0] rdata, wdata;
  logic [7:0]  wstrb;
  logic [1:0]  rresp, bresp;

  logic [63:0] shadow [0:mem_words-1];
  logic [63:0] cyc_since_rst;
  int          cycles, n_checks, n_errs, t_checks, t_errs;

  mem_bus_top dut0 (
    .clk(clk), .rst(rst),
    .io_master_araddr_o(araddr), .io_master_arsize_o(arsize),
    .io_master_arvalid_o(arvalid), .io_master_arready_i(arready),
    .io_master_rdata_i(rdata), .io_master_rresp_i(rresp), .io_master_rvalid_i(rvalid),
    .io_master_awaddr_o(awaddr), .io_master_awsize_o(awsize),
    .io_master_awvalid_o(awvalid), .io_master_awready_i(awready),
    .io_master_wdata_o(wdata), .io_master_wstrb_o(wstrb),
    .io_master_wvalid_o(wvalid), .io_master_wready_i(wready),
    .io_master_bresp_i(bresp), .io_master_bvalid_i(bvalid),
    .ifu_araddr_i(ifu_araddr), .ifu_arvalid_i(ifu_arvalid),
    .ifu_rdata_o(ifu_rdata_o), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr), .lsu_arvalid_i(lsu_arvalid), .lsu_rstrb_i(lsu_rstrb),
    .lsu_rdata_o(lsu_rdata_o), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr), .lsu_wdata_i(lsu_wdata), .lsu_wstrb_i(lsu_wstrb),
    .lsu_wvalid_i(lsu_wvalid), .lsu_wready_o(lsu_wready_o)
  );

  axi_slave_model u_slave (
    .clk(clk), .rst(rst),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    cyc_since_rst <= rst ? 64'd0 : cyc_since_rst + 64'd1; // tracks mtime
    if (cycles > cyc_limit)
    begin
      $display("timeout after %0d cycles, a transaction never completed", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] mem_addr(input logic [7:0] idx, input logic half,
                                           input logic [1:0] off);
    return 32'h8000_0000 | {21'd0, idx, half, off};
  endfunction

  function automatic logic [2:0] exp_size(input logic [7:0] strb);
    case (strb)
      8'h01: return 3'd0;
      8'h03: return 3'd1;
      8'h0f: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    return addr[2] ? shadow[addr[10:3]][63:32] : shadow[addr[10:3]][31:0];
  endfunction

  task automatic shadow_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    logic [3:0]  s;
    logic [31:0] d;
    s = strb << addr[1:0];
    d = data << {addr[1:0], 3'b000};
    for (int b = 0; b < 4; b++)
      if (s[b])
        shadow[addr[10:3]][32*addr[2] + 8*b +: 8] = d[8*b +: 8];
  endtask

  task automatic complain(input string msg);
    $display("%s", msg);
    n_errs++;
    t_errs++;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    t_checks++;
    if (got !== exp)
      complain($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, t_checks, t_errs);
    t_checks = 0;
    t_errs = 0;
  endtask

  // one transaction per source, operands already on the lsu signals
  task automatic run_txn(input bit use_ifu, input bit use_lsu, input bit lsu_store,
                         input bit is_timer, output int ifu_at, output int lsu_at,
                         output logic [31:0] ifu_word, output logic [31:0] lsu_word);
    int   n;
    bit   ifu_done, lsu_done, lsu_pulse, other_pulse;
    logic [7:0] ar_strb;
    n = 0;
    ifu_at = 0;
    lsu_at = 0;
    ifu_done = !use_ifu;
    lsu_done = !use_lsu;
    ifu_arvalid <= use_ifu;
    lsu_arvalid <= use_lsu && !lsu_store;
    lsu_wvalid  <= use_lsu && lsu_store;
    while (!(ifu_done && lsu_done))
    begin
      @(negedge clk);
      n++;
      lsu_pulse   = lsu_store ? lsu_wready_o : lsu_rvalid_o;
      other_pulse = lsu_store ? lsu_rvalid_o : lsu_wready_o;
      ar_strb = (!lsu_done && !lsu_store) ? lsu_rstrb : 8'h0f; // lsu wins while pending
      if (arvalid && arready)
        check_val("io_master_arsize", 32'(arsize), 32'(exp_size(ar_strb)));
      if (awvalid && awready)
        check_val("io_master_awsize", 32'(awsize), 32'(exp_size(lsu_wstrb)));
      if (is_timer && arvalid)
        complain("timer load raised io_master_arvalid");
      if (ifu_rvalid_o && ifu_done)
        complain("ifu completion pulsed with no fetch pending");
      if (lsu_pulse && lsu_done)
        complain("lsu completion pulsed with no lsu request pending");
      if (other_pulse)
        complain("wrong lsu completion pulsed for the request kind");
      if (ifu_rvalid_o && !ifu_done)
      begin
        ifu_at = n;
        ifu_word = ifu_rdata_o;
      end
      if (lsu_pulse && !lsu_done)
      begin
        lsu_at = n;
        lsu_word = lsu_rdata_o;
      end
      @(posedge clk);
      if (ifu_at != 0 && !ifu_done)
      begin
        ifu_done = 1'b1;
        ifu_arvalid <= 1'b0;
      end
      if (lsu_at != 0 && !lsu_done)
      begin
        lsu_done = 1'b1;
        lsu_arvalid <= 1'b0;
        lsu_wvalid  <= 1'b0;
      end
    end
    @(negedge clk);
    if (ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o)
      complain("completion pulse wider than one cycle");
    @(posedge clk);
  endtask

  initial
  begin
    int          ia, il;
    logic [31:0] wi, wl, a, prev_lo, hi_lo, lo_bound;
    logic [7:0]  strb_set [3];
    strb_set = '{8'h01, 8'h03, 8'h0f};
    clk = 1'b0;
    rst = 1'b1;
    cycles = 0;
    cyc_since_rst = 64'd0;
    n_checks = 0;
    n_errs = 0;
    t_checks = 0;
    t_errs = 0;
    ifu_araddr = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb = '0;
    lsu_awaddr = '0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    lsu_wvalid = 1'b0;
    void'($urandom(seed));
    for (int i = 0; i < mem_words; i++)
      shadow[i] = {32'h1000_0000 + i * 32'h0001_0003, 32'hf000_0000 ^ (i * 32'h0003_0101)};
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < n_fetch; i++)
    begin
      ifu_araddr <= mem_addr(8'($urandom), 1'($urandom), 2'b00);
      run_txn(1, 0, 0, 0, ia, il, wi, wl);
      check_val("ifu_rdata_o", wi, shadow_word(ifu_araddr));
    end
    end_test("1 fetch reads");

    for (int s = 0; s < 3; s++)
      for (int off = 0; off < 4; off++)
        for (int r = 0; r < n_rep; r++)
        begin
          a = mem_addr(8'($urandom), 1'($urandom), 2'(off));
          lsu_awaddr <= a;
          lsu_wdata  <= $urandom;
          lsu_wstrb  <= strb_set[s];
          run_txn(0, 1, 1, 0, ia, il, wi, wl);
          shadow_store(a, lsu_wdata, strb_set[s][3:0]);
          lsu_araddr <= a;
          lsu_rstrb  <= strb_set[s];
          run_txn(0, 1, 0, 0, ia, il, wi, wl);
          check_val("lsu_rdata_o", wl, shadow_word(a));
        end
    end_test("2 store then load, 3 size encoding");

    for (int i = 0; i < n_prio; i++)
    begin
      ifu_araddr <= mem_addr(8'($urandom), 1'($urandom), 2'b00);
      lsu_araddr <= mem_addr(8'($urandom), 1'($urandom), 2'b00);
      lsu_rstrb  <= 8'h0f;
      run_txn(1, 1, 0, 0, ia, il, wi, wl);
      if (il >= ia)
        complain("ifu completed before the lsu load issued in the same cycle");
      check_val("ifu_rdata_o", wi, shadow_word(ifu_araddr));
      check_val("lsu_rdata_o", wl, shadow_word(lsu_araddr));
    end
    end_test("4 priority");

    prev_lo = '0;
    for (int i = 0; i < n_timer; i++)
    begin
      lo_bound = cyc_since_rst[31:0]; // mtime is at least this before the load starts
      lsu_araddr <= (i % 2 == 0) ? rtc_addr : rtc_addr_up;
      lsu_rstrb  <= 8'h0f;
      run_txn(0, 1, 0, 1, ia, il, wi, wl);
      // grant one edge after drive, result visible after the third edge past grant
      check_val("timer latency", 32'(il), 32'(timer_lat + 2));
      if (i % 2 == 0)
      begin
        if (wl < prev_lo || wl < lo_bound || wl > cyc_since_rst[31:0])
          complain($sformatf("Error: mtime low %h out of range %h to %h, previous %h", wl,
                             lo_bound, cyc_since_rst[31:0], prev_lo));
        prev_lo = wl;
      end
      else
      begin
        hi_lo = cyc_since_rst[63:32];
        check_val("mtime high", wl, hi_lo);
      end
    end
    end_test("5 timer");

    $display("checks %0d, errors %0d, cycles %0d", n_checks, n_errs, cycles);
    if (n_errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: files.f
logic/bus_pkg.sv
logic/mem_map_pkg.sv
logic/mem_req_if.sv
logic/req_arbiter.sv
logic/axi_issue.sv
logic/resp_router.sv
logic/clint_timer.sv
logic/mem_bus_top.sv
test/axi_slave_model.sv
test/tb_mem_bus.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_bus \
  -f files.f --Mdir obj_dir -o sim_mem_bus

./obj_dir/sim_mem_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1
